/* hw/tag_lookup_pkg.sv */
// Tag lookup shared definitions
// Array geometry, entry layout and controller states
`default_nettype none

package tag_lookup_pkg;

  // Number of sets in each way
  localparam int SET_NUM = 256;

  // Set index width
  localparam int IDX_W = 8;

  // Stored tag bits per entry
  localparam int TAG_W = 6;

  // Tag plus valid bit
  localparam int ENTRY_W = TAG_W + 1;

  // Valid flag sits above the tag
  localparam int VALID_BIT = 6;

  // Controller sequencing
  typedef enum logic [1:0] {
    ST_CLEAR,   // post-reset sweep writing zeros
    ST_IDLE,    // waiting for a strobe
    ST_ACCESS   // lookup read in flight
  } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/fpga_ram.sv */
// Single-port RAM column
// Synchronous write, registered read address, generic width and depth
`timescale 1ns/10ps
`default_nettype none

module fpga_ram #(
  parameter int DATA_W = 1,
  parameter int ADDR_W = 8
) (
  input  logic              CLK,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] din,
  input  logic              we,
  output logic [DATA_W-1:0] dout
);

  // Storage, one word per address
  logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

  // Read address captured every edge
  logic [ADDR_W-1:0] addr_q;

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= din;
    end
    addr_q <= addr;
  end

  // Read through the registered address
  // A write shows up on the next cycle's dout
  assign dout = mem[addr_q];

endmodule

`default_nettype wire

/* hw/spsram_256x7.sv */
// 256x7 single-port tag SRAM
// Active-low chip enable, global and per-bit write enables
// Address holding register keeps q stable while deselected
`timescale 1ns/10ps
`default_nettype none

module spsram_256x7 (
  input  logic                               CLK,
  input  logic [tag_lookup_pkg::IDX_W-1:0]   a,
  input  logic                               cen,
  input  logic [tag_lookup_pkg::ENTRY_W-1:0] d,
  input  logic                               gwen,
  input  logic [tag_lookup_pkg::ENTRY_W-1:0] wen,
  output logic [tag_lookup_pkg::ENTRY_W-1:0] q
);

  import tag_lookup_pkg::*;

  // Last address seen with the chip selected
  logic [IDX_W-1:0] addr_holding;

  // Address actually sent to the columns
  logic [IDX_W-1:0] ram_addr;

  // Per-column write strobes
  logic [ENTRY_W-1:0] col_we;

  // Capture only on selected cycles
  always_ff @(posedge CLK) begin
    if (!cen) begin
      addr_holding <= a;
    end
  end

  // Deselected: replay the held address
  // so the column read registers keep pointing at the same word
  assign ram_addr = cen ? addr_holding : a;

  // One bit-wide column per entry bit
  for (genvar i = 0; i < ENTRY_W; i++) begin : g_col

    // Write needs chip, global and bit enable all low
    assign col_we[i] = ~cen & ~gwen & ~wen[i];

    fpga_ram #(
      .DATA_W (1),
      .ADDR_W (IDX_W)
    ) u_col (
      .CLK  (CLK),
      .addr (ram_addr),
      .din  (d[i]),
      .we   (col_we[i]),
      .dout (q[i])
    );

  end

endmodule

`default_nettype wire

/* hw/tag_ctrl.sv */
// Tag array controller
// Clears both ways after reset, then maps lookup, refill and
// invalidate strobes onto the SRAM pins of the two ways
`timescale 1ns/10ps
`default_nettype none

module tag_ctrl (
  input  logic                               CLK,
  input  logic                               rst_n,
  input  logic                               lookup,
  input  logic                               refill,
  input  logic                               invalidate,
  input  logic [tag_lookup_pkg::IDX_W-1:0]   index,
  input  logic [tag_lookup_pkg::TAG_W-1:0]   tag,
  input  logic                               victim_way,
  output logic                               busy,
  output logic                               cen0,
  output logic                               cen1,
  output logic                               gwen,
  output logic [tag_lookup_pkg::ENTRY_W-1:0] wen,
  output logic [tag_lookup_pkg::IDX_W-1:0]   addr,
  output logic [tag_lookup_pkg::ENTRY_W-1:0] din,
  output logic                               compare,
  output logic [tag_lookup_pkg::TAG_W-1:0]   cmp_tag,
  output logic                               clear_done
);

  import tag_lookup_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // One extra bit so the count can reach SET_NUM
  logic [IDX_W:0] sweep_cnt;
  logic           sweep_wr;
  logic           sweep_last;

  // Decoded strobes, already priority-resolved
  logic accept;
  logic do_inv;
  logic do_ref;
  logic do_lkp;

  // Writes for indices 0..SET_NUM-1, then one closing cycle
  assign sweep_wr   = ~sweep_cnt[IDX_W];
  assign sweep_last = (sweep_cnt == (IDX_W+1)'(SET_NUM));

  // Strobes only count once the sweep is over
  assign accept = (state_q != ST_CLEAR);
  assign do_inv = accept & invalidate;
  assign do_ref = accept & refill & ~invalidate;
  assign do_lkp = accept & lookup & ~refill & ~invalidate;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_CLEAR: begin
        if (sweep_last) begin
          state_d = ST_IDLE;
        end
      end
      // Lookups may follow each other, stay in ACCESS then
      default: begin
        state_d = do_lkp ? ST_ACCESS : ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state_q   <= ST_CLEAR;
      sweep_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_CLEAR && !sweep_last) begin
        sweep_cnt <= sweep_cnt + 1'b1;
      end
    end
  end

  // Request tag, compared when the read data returns
  always_ff @(posedge CLK) begin
    if (do_lkp) begin
      cmp_tag <= tag;
    end
  end

  // Read data of the accepted lookup is on q now
  assign compare    = (state_q == ST_ACCESS);
  assign busy       = (state_q == ST_CLEAR);
  assign clear_done = (state_q != ST_CLEAR);

  // SRAM pin patterns, idle by default
  always_comb begin
    cen0 = 1'b1;
    cen1 = 1'b1;
    gwen = 1'b1;
    wen  = '1;
    addr = index;
    din  = '0;
    if (state_q == ST_CLEAR) begin
      // Zero both ways at the sweep index
      cen0 = ~sweep_wr;
      cen1 = ~sweep_wr;
      gwen = 1'b0;
      wen  = '0;
      addr = sweep_cnt[IDX_W-1:0];
    end else if (do_inv) begin
      // Drop valid only, tag bits untouched
      cen0           = 1'b0;
      cen1           = 1'b0;
      gwen           = 1'b0;
      wen[VALID_BIT] = 1'b0;
    end else if (do_ref) begin
      // Only the victim way is selected
      cen0                = victim_way;
      cen1                = ~victim_way;
      gwen                = 1'b0;
      wen                 = '0;
      din[TAG_W-1:0]      = tag;
      din[VALID_BIT]      = 1'b1;
    end else if (do_lkp) begin
      // Read both ways
      cen0 = 1'b0;
      cen1 = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/tag_hit_select.sv */
// Hit and victim selection for the two tag ways
// Compares both read entries against the request tag and keeps
// the replacement choice with a round-robin pointer
`timescale 1ns/10ps
`default_nettype none

module tag_hit_select (
  input  logic                               CLK,
  input  logic                               rst_n,
  input  logic [tag_lookup_pkg::ENTRY_W-1:0] q0,
  input  logic [tag_lookup_pkg::ENTRY_W-1:0] q1,
  input  logic                               compare,
  input  logic [tag_lookup_pkg::TAG_W-1:0]   cmp_tag,
  input  logic                               clear_done,
  output logic                               lookup_done,
  output logic                               hit,
  output logic                               hit_way,
  output logic                               victim_way
);

  import tag_lookup_pkg::*;

  // Per-way match, valid and tag equal
  logic match0;
  logic match1;

  logic valid0;
  logic valid1;
  logic both_valid;

  // Miss on the current compare cycle
  logic miss;

  // Replacement state
  logic rr_q;
  logic victim_q;
  logic victim_new;

  assign valid0     = q0[VALID_BIT];
  assign valid1     = q1[VALID_BIT];
  assign both_valid = valid0 & valid1;

  assign match0 = valid0 & (q0[TAG_W-1:0] == cmp_tag);
  assign match1 = valid1 & (q1[TAG_W-1:0] == cmp_tag);

  // Result is due in the cycle the read data comes back
  assign lookup_done = compare;
  assign hit         = compare & (match0 | match1);
  assign miss        = compare & ~(match0 | match1);

  // Way 0 wins if both were to match
  assign hit_way = match1 & ~match0;

  // First free way, else the round-robin pick
  always_comb begin
    if (!valid0) begin
      victim_new = 1'b0;
    end else if (!valid1) begin
      victim_new = 1'b1;
    end else begin
      victim_new = rr_q;
    end
  end

  // New choice shows on the miss cycle itself, then held
  assign victim_way = miss ? victim_new : victim_q;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rr_q     <= 1'b0;
      victim_q <= 1'b0;
    end else if (!clear_done) begin
      // Arrays are being wiped, restart replacement too
      rr_q     <= 1'b0;
      victim_q <= 1'b0;
    end else if (miss) begin
      victim_q <= victim_new;
      // Pointer only moves on full-set misses
      if (both_valid) begin
        rr_q <= ~rr_q;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/tag_lookup_top.sv */
// Two-way tag lookup unit
// Controller, two 256x7 tag ways and the hit selector
`timescale 1ns/10ps
`default_nettype none

module tag_lookup_top (
  input  logic                             CLK,
  input  logic                             rst_n,
  input  logic                             lookup,
  input  logic                             refill,
  input  logic                             invalidate,
  input  logic [tag_lookup_pkg::IDX_W-1:0] index,
  input  logic [tag_lookup_pkg::TAG_W-1:0] tag,
  output logic                             busy,
  output logic                             lookup_done,
  output logic                             hit,
  output logic                             hit_way,
  output logic                             victim_way
);

  import tag_lookup_pkg::*;

  // Per-way selects
  logic cen0;
  logic cen1;

  // Buses shared by both ways
  logic               gwen;
  logic [ENTRY_W-1:0] wen;
  logic [IDX_W-1:0]   addr;
  logic [ENTRY_W-1:0] din;

  // Read data per way
  logic [ENTRY_W-1:0] q0;
  logic [ENTRY_W-1:0] q1;

  // Controller to selector
  logic             compare;
  logic [TAG_W-1:0] cmp_tag;
  logic             clear_done;

  tag_ctrl u_ctrl (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .lookup     (lookup),
    .refill     (refill),
    .invalidate (invalidate),
    .index      (index),
    .tag        (tag),
    .victim_way (victim_way),
    .busy       (busy),
    .cen0       (cen0),
    .cen1       (cen1),
    .gwen       (gwen),
    .wen        (wen),
    .addr       (addr),
    .din        (din),
    .compare    (compare),
    .cmp_tag    (cmp_tag),
    .clear_done (clear_done)
  );

  // Way 0 tags
  spsram_256x7 way0 (
    .CLK  (CLK),
    .a    (addr),
    .cen  (cen0),
    .d    (din),
    .gwen (gwen),
    .wen  (wen),
    .q    (q0)
  );

  // Way 1 tags
  spsram_256x7 way1 (
    .CLK  (CLK),
    .a    (addr),
    .cen  (cen1),
    .d    (din),
    .gwen (gwen),
    .wen  (wen),
    .q    (q1)
  );

  tag_hit_select u_hit (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .q0          (q0),
    .q1          (q1),
    .compare     (compare),
    .cmp_tag     (cmp_tag),
    .clear_done  (clear_done),
    .lookup_done (lookup_done),
    .hit         (hit),
    .hit_way     (hit_way),
    .victim_way  (victim_way)
  );

endmodule

`default_nettype wire

/* testbench/tb_tag_lookup.sv */
// Testbench for the two-way tag lookup unit
// Reference model of both ways and the victim rule, with every
// response checked by concurrent assertions
`timescale 1ns/10ps
`default_nettype none

module tb_tag_lookup;

  import tag_lookup_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 16;
  localparam int SEED       = 31464;
  localparam int N_RANDOM   = 3000;
  // Upper bound on the directed cycles, busy phase included
  localparam int N_DIRECTED = 600;
  localparam int WDOG_CYCLES = (RST_CYCLES + SET_NUM + 1 + N_DIRECTED + N_RANDOM) * 3;
  // Only the valid bit enabled
  localparam logic [ENTRY_W-1:0] INV_WEN = ~(ENTRY_W'(1) << VALID_BIT);

  logic             CLK;
  logic             rst_n;
  logic             lookup;
  logic             refill;
  logic             invalidate;
  logic [IDX_W-1:0] index;
  logic [TAG_W-1:0] tag;
  logic             busy;
  logic             lookup_done;
  logic             hit;
  logic             hit_way;
  logic             victim_way;

  // Model contents of both ways
  logic [ENTRY_W-1:0] ref_way0 [SET_NUM];
  logic [ENTRY_W-1:0] ref_way1 [SET_NUM];
  logic ref_rr;
  logic ref_victim_held;

  // Expected outputs for the current cycle
  int   cyc_since_rst;
  logic exp_busy;
  logic exp_done;
  logic exp_hit;
  logic exp_way;
  logic exp_single;
  logic exp_victim;

  int err_cnt;
  int n_lookups;

  tag_lookup_top dut0 (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .lookup      (lookup),
    .refill      (refill),
    .invalidate  (invalidate),
    .index       (index),
    .tag         (tag),
    .busy        (busy),
    .lookup_done (lookup_done),
    .hit         (hit),
    .hit_way     (hit_way),
    .victim_way  (victim_way)
  );

  initial begin : clock_gen
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin : watchdog
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, stimulus never finished", WDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  task automatic log_error(input string msg);
    err_cnt = err_cnt + 1;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  // Sweep lasts SET_NUM + 1 cycles after reset release
  assign exp_busy = (cyc_since_rst <= SET_NUM);

  always @(posedge CLK) begin : ref_model
    logic v0;
    logic v1;
    logic m0;
    logic m1;
    logic vnew;
    if (!rst_n) begin
      for (int i = 0; i < SET_NUM; i++) begin
        ref_way0[i] = '0;
        ref_way1[i] = '0;
      end
      ref_rr          = 1'b0;
      ref_victim_held = 1'b0;
      cyc_since_rst <= 0;
      exp_done      <= 1'b0;
      exp_hit       <= 1'b0;
      exp_way       <= 1'b0;
      exp_single    <= 1'b0;
      exp_victim    <= 1'b0;
    end else begin
      exp_done   <= 1'b0;
      exp_hit    <= 1'b0;
      exp_way    <= 1'b0;
      exp_single <= 1'b0;
      if (cyc_since_rst <= SET_NUM) begin
        cyc_since_rst <= cyc_since_rst + 1;
      end
      // Priority invalidate, refill, lookup
      if (!exp_busy && invalidate) begin
        ref_way0[index][VALID_BIT] = 1'b0;
        ref_way1[index][VALID_BIT] = 1'b0;
      end else if (!exp_busy && refill) begin
        // Victim as shown in this very cycle
        if (exp_victim) begin
          ref_way1[index] = {1'b1, tag};
        end else begin
          ref_way0[index] = {1'b1, tag};
        end
      end else if (!exp_busy && lookup) begin
        n_lookups = n_lookups + 1;
        v0 = ref_way0[index][VALID_BIT];
        v1 = ref_way1[index][VALID_BIT];
        m0 = v0 && (ref_way0[index][TAG_W-1:0] == tag);
        m1 = v1 && (ref_way1[index][TAG_W-1:0] == tag);
        exp_done   <= 1'b1;
        exp_hit    <= m0 | m1;
        exp_way    <= m1;
        exp_single <= m0 ^ m1;
        if (!(m0 || m1)) begin
          // First free way, else round robin
          vnew = !v0 ? 1'b0 : (!v1 ? 1'b1 : ref_rr);
          if (v0 && v1) begin
            ref_rr = ~ref_rr;
          end
          ref_victim_held = vnew;
        end
      end
      exp_victim <= ref_victim_held;
    end
  end

  a_busy: assert property (@(posedge CLK) disable iff (!rst_n) busy == exp_busy)
    else log_error("busy does not follow the clear sweep timing");
  a_done: assert property (@(posedge CLK) disable iff (!rst_n) lookup_done == exp_done)
    else log_error("lookup_done not one cycle after an accepted lookup");
  a_hit: assert property (@(posedge CLK) disable iff (!rst_n) exp_done |-> hit == exp_hit)
    else log_error("hit differs from the model");
  a_no_hit: assert property (@(posedge CLK) disable iff (!rst_n) !exp_done |-> !hit)
    else log_error("hit raised without lookup_done");
  // Multi-hit sets are out of scope for hit_way
  a_way: assert property (@(posedge CLK) disable iff (!rst_n)
    (exp_done && exp_single) |-> hit_way == exp_way)
    else log_error("hit_way differs from the model");
  a_victim: assert property (@(posedge CLK) disable iff (!rst_n) victim_way == exp_victim)
    else log_error("victim_way differs from the model");

  // SRAM pin patterns per accepted request
  a_inv_pins: assert property (@(posedge CLK) disable iff (!rst_n)
    (!exp_busy && invalidate) |->
      (!dut0.cen0 && !dut0.cen1 && !dut0.gwen && dut0.wen == INV_WEN && dut0.addr == index))
    else log_error("invalidate pins not valid-bit write on both ways");
  a_ref_pins: assert property (@(posedge CLK) disable iff (!rst_n)
    (!exp_busy && refill && !invalidate) |->
      (dut0.cen0 == exp_victim && dut0.cen1 == !exp_victim && !dut0.gwen &&
       dut0.wen == '0 && dut0.din == {1'b1, tag} && dut0.addr == index))
    else log_error("refill pins do not write the tag into the victim way");
  a_lkp_pins: assert property (@(posedge CLK) disable iff (!rst_n)
    (!exp_busy && lookup && !refill && !invalidate) |->
      (!dut0.cen0 && !dut0.cen1 && dut0.gwen && dut0.addr == index))
    else log_error("lookup pins are not a read of both ways");

  task automatic drive_op(input logic lk, input logic rf, input logic inv,
                          input logic [IDX_W-1:0] idx, input logic [TAG_W-1:0] tg);
    @(posedge CLK);
    lookup     <= lk;
    refill     <= rf;
    invalidate <= inv;
    index      <= idx;
    tag        <= tg;
  endtask

  task automatic wait_not_busy;
    int n;
    n = 0;
    @(negedge CLK);
    while (busy && n <= 2 * SET_NUM) begin
      n++;
      @(negedge CLK);
    end
    if (busy) begin
      err_cnt = err_cnt + 1;
      $display("busy never fell after the clear sweep");
    end
  endtask

  initial begin : stimulus
    int unsigned seed_val;
    int r;
    logic [IDX_W-1:0] ri;
    logic [TAG_W-1:0] rt;
    rst_n      = 1'b0;
    lookup     = 1'b0;
    refill     = 1'b0;
    invalidate = 1'b0;
    index      = '0;
    tag        = '0;
    err_cnt    = 0;
    n_lookups  = 0;
    seed_val   = $urandom(SEED);
    repeat (RST_CYCLES) @(posedge CLK);
    rst_n <= 1'b1;

    // Strobes during the sweep must be dropped
    repeat (200) begin
      drive_op(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
               1'($urandom_range(0, 1)), IDX_W'($urandom_range(0, 7)),
               TAG_W'($urandom()));
    end
    drive_op(1'b0, 1'b0, 1'b0, '0, '0);
    wait_not_busy();

    // Sets targeted during the sweep are still empty
    for (int i = 0; i < 8; i++) begin
      drive_op(1'b1, 1'b0, 1'b0, IDX_W'(i), '0);
    end

    // Cleared sets miss with victim 0
    for (int i = 0; i < 16; i++) begin
      drive_op(1'b1, 1'b0, 1'b0, IDX_W'($urandom()), TAG_W'($urandom()));
    end

    // Miss, refill into way 0, then hit
    drive_op(1'b1, 1'b0, 1'b0, 8'h21, 6'h15);
    drive_op(1'b0, 1'b1, 1'b0, 8'h21, 6'h15);
    drive_op(1'b1, 1'b0, 1'b0, 8'h21, 6'h15);
    // Second tag lands in the free way 1
    drive_op(1'b1, 1'b0, 1'b0, 8'h21, 6'h2a);
    drive_op(1'b0, 1'b1, 1'b0, 8'h21, 6'h2a);
    drive_op(1'b1, 1'b0, 1'b0, 8'h21, 6'h2a);

    // Full set, victims alternate
    for (int i = 0; i < 6; i++) begin
      drive_op(1'b1, 1'b0, 1'b0, 8'h21, 6'(i + 3));
      drive_op(1'b0, 1'b1, 1'b0, 8'h21, 6'(i + 3));
    end
    drive_op(1'b1, 1'b0, 1'b0, 8'h21, 6'h07);
    drive_op(1'b1, 1'b0, 1'b0, 8'h21, 6'h08);

    // Invalidate, then the very next lookup misses
    drive_op(1'b0, 1'b0, 1'b1, 8'h21, 6'h3f);
    drive_op(1'b1, 1'b0, 1'b0, 8'h21, 6'h08);
    drive_op(1'b1, 1'b0, 1'b0, 8'h21, 6'h07);
    drive_op(1'b0, 1'b0, 1'b0, 8'h21, 6'h07);

    // Simultaneous strobes
    drive_op(1'b1, 1'b1, 1'b0, 8'h40, 6'h11);
    drive_op(1'b1, 1'b0, 1'b0, 8'h40, 6'h11);
    drive_op(1'b1, 1'b1, 1'b1, 8'h40, 6'h11);
    drive_op(1'b1, 1'b0, 1'b0, 8'h40, 6'h11);
    drive_op(1'b0, 1'b1, 1'b1, 8'h40, 6'h12);
    drive_op(1'b1, 1'b0, 1'b0, 8'h40, 6'h12);

    // Random mix over a few sets and tags for frequent hits
    for (int i = 0; i < N_RANDOM; i++) begin
      r  = $urandom_range(0, 99);
      ri = IDX_W'($urandom_range(0, 15));
      rt = TAG_W'($urandom_range(0, 7));
      if (r < 50) begin
        drive_op(1'b1, 1'b0, 1'b0, ri, rt);
      end else if (r < 75) begin
        drive_op(1'b0, 1'b1, 1'b0, ri, rt);
      end else if (r < 85) begin
        drive_op(1'b0, 1'b0, 1'b1, ri, rt);
      end else if (r < 92) begin
        drive_op(1'b0, 1'b0, 1'b0, ri, rt);
      end else begin
        drive_op(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                 1'($urandom_range(0, 1)), ri, rt);
      end
    end

    drive_op(1'b0, 1'b0, 1'b0, '0, '0);
    repeat (4) @(posedge CLK);
    $display("Lookups checked: %0d, errors: %0d", n_lookups, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hw/tag_lookup_pkg.sv
hw/fpga_ram.sv
hw/spsram_256x7.sv
hw/tag_ctrl.sv
hw/tag_hit_select.sv
hw/tag_lookup_top.sv
testbench/tb_tag_lookup.sv

/* Bender.yml */
package:
  name: tag_lookup

sources:
  - hw/tag_lookup_pkg.sv
  - hw/fpga_ram.sv
  - hw/spsram_256x7.sv
  - hw/tag_ctrl.sv
  - hw/tag_hit_select.sv
  - hw/tag_lookup_top.sv
  - target: simulation
    files:
      - testbench/tb_tag_lookup.sv
